//--- verilog/cpu_pkg.sv
package cpu_pkg;

	// memory sizes in 32-bit words.
	localparam int imem_depth = 256;
	localparam int imem_addr_bits = 8;
	localparam int dmem_depth = 256;

	// -------------------------------------------------------------------
	// instruction fields
	// -------------------------------------------------------------------
	typedef enum logic [5:0] {
		op_special = 6'h00,
		op_j       = 6'h02,
		op_beq     = 6'h04,
		op_ori     = 6'h0d,
		op_lui     = 6'h0f,
		op_lw      = 6'h23,
		op_sw      = 6'h2b
	} opcode_e;

	typedef enum logic [5:0] {
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_slt  = 6'h2a
	} funct_e;

	// -------------------------------------------------------------------
	// datapath controls
	// -------------------------------------------------------------------
	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt,
		alu_lui
	} alu_op_e;

	typedef enum logic [1:0] {
		fwd_reg, // value read in decode.
		fwd_mem, // alu result now in the memory stage.
		fwd_wb   // data being written back.
	} fwd_sel_e;

	typedef enum logic {
		wb_alu,
		wb_load
	} wb_sel_e;

endpackage

//--- verilog/fetch_stage.sv
module fetch_stage (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               imem_we,
	input  logic [cpu_pkg::imem_addr_bits-1:0] imem_addr,
	input  logic [31:0]                        imem_data,
	input  logic                               stall,
	input  logic                               redirect,
	input  logic [31:0]                        target,
	output logic [31:0]                        d_instr,
	output logic [31:0]                        d_pc_plus4
);
	import cpu_pkg::*;

	logic [31:0] pc;
	logic [31:0] pc_plus4;
	logic [31:0] f_instr;
	logic [31:0] imem [imem_depth];

	assign pc_plus4 = pc + 32'd4;
	assign f_instr = imem[pc[imem_addr_bits+1:2]]; // word index of a byte address.

	// the program is loaded only while the core is held in reset.
	always_ff @(posedge clk) begin
		if (!rst_n && imem_we) begin
			imem[imem_addr] <= imem_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (!stall) begin
			pc <= redirect ? target : pc_plus4;
		end
	end

	// F/D register, an all-zero word decodes as a bubble.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			d_instr <= '0;
		end else if (!stall) begin
			d_instr <= f_instr;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			d_pc_plus4 <= pc_plus4;
		end
	end

endmodule

//--- verilog/decode_stage.sv
module decode_stage (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                stall,
	input  logic [31:0]         d_instr,
	input  logic [31:0]         d_pc_plus4,
	input  cpu_pkg::fwd_sel_e   fwd_d1,
	input  cpu_pkg::fwd_sel_e   fwd_d2,
	input  logic [31:0]         m_alu_result,
	input  logic [31:0]         w_data,
	input  logic [4:0]          w_dest,
	input  logic                w_reg_write,
	output logic                redirect,
	output logic [31:0]         target,
	output logic [4:0]          d_rs,
	output logic [4:0]          d_rt,
	output logic                d_uses_rt,
	output logic                d_is_branch,
	output logic [4:0]          e_rs,
	output logic [4:0]          e_rt,
	output logic [4:0]          e_dest,
	output logic                e_reg_write,
	output logic                e_mem_write,
	output cpu_pkg::wb_sel_e    e_wb_sel,
	output cpu_pkg::alu_op_e    e_alu_op,
	output logic                e_alu_src,
	output logic [31:0]         e_a,
	output logic [31:0]         e_b,
	output logic [31:0]         e_imm
);
	import cpu_pkg::*;

	opcode_e     op;
	funct_e      funct;
	logic        reg_write, mem_write, alu_src, uses_rs, sign_ext, is_jump;
	logic [4:0]  dest;
	wb_sel_e     wb_sel;
	alu_op_e     alu_op;
	logic [31:0] rf_a, rf_b, a, b, imm;
	logic [31:0] regs [32];

	assign op = opcode_e'(d_instr[31:26]);
	assign funct = funct_e'(d_instr[5:0]);

	// -------------------------------------------------------------------
	// control decode
	// -------------------------------------------------------------------
	always_comb begin
		reg_write = 1'b0;
		mem_write = 1'b0;
		wb_sel = wb_alu;
		alu_op = alu_add;
		alu_src = 1'b0;
		dest = d_instr[15:11];
		uses_rs = 1'b1;
		d_uses_rt = 1'b0;
		sign_ext = 1'b1;
		d_is_branch = 1'b0;
		is_jump = 1'b0;
		case (op)
			op_special: begin
				d_uses_rt = 1'b1;
				reg_write = 1'b1;
				case (funct)
					fn_addu: alu_op = alu_add;
					fn_subu: alu_op = alu_sub;
					fn_and: alu_op = alu_and;
					fn_or: alu_op = alu_or;
					fn_slt: alu_op = alu_slt;
					default: reg_write = 1'b0; // includes the all-zero bubble.
				endcase
			end
			op_ori: begin
				reg_write = 1'b1;
				alu_op = alu_or;
				alu_src = 1'b1;
				sign_ext = 1'b0;
				dest = d_instr[20:16];
			end
			op_lui: begin
				reg_write = 1'b1;
				alu_op = alu_lui;
				alu_src = 1'b1;
				sign_ext = 1'b0;
				uses_rs = 1'b0;
				dest = d_instr[20:16];
			end
			op_lw: begin
				reg_write = 1'b1;
				wb_sel = wb_load;
				alu_src = 1'b1;
				dest = d_instr[20:16];
			end
			op_sw: begin
				// rt travels as dest so the store data can be matched in memory.
				mem_write = 1'b1;
				alu_src = 1'b1;
				dest = d_instr[20:16];
			end
			op_beq: begin
				d_is_branch = 1'b1;
				d_uses_rt = 1'b1;
			end
			op_j: begin
				is_jump = 1'b1;
				uses_rs = 1'b0;
			end
			default: uses_rs = 1'b0;
		endcase
	end

	assign d_rs = uses_rs ? d_instr[25:21] : 5'd0;
	assign d_rt = d_instr[20:16];

	// -------------------------------------------------------------------
	// register file and operands
	// -------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (w_reg_write && w_dest != 5'd0) begin
			regs[w_dest] <= w_data;
		end
	end

	assign rf_a = (d_rs == 5'd0) ? 32'd0 : regs[d_rs];
	assign rf_b = (d_rt == 5'd0) ? 32'd0 : regs[d_rt];

	// the writeback path also covers a register written in this cycle.
	assign a = (fwd_d1 == fwd_mem) ? m_alu_result : (fwd_d1 == fwd_wb) ? w_data : rf_a;
	assign b = (fwd_d2 == fwd_mem) ? m_alu_result : (fwd_d2 == fwd_wb) ? w_data : rf_b;

	assign imm = sign_ext ? {{16{d_instr[15]}}, d_instr[15:0]} : {16'd0, d_instr[15:0]};

	assign redirect = is_jump || (d_is_branch && a == b);
	assign target = is_jump ? {d_pc_plus4[31:28], d_instr[25:0], 2'b00}
		: d_pc_plus4 + {imm[29:0], 2'b00};

	// D/E register, a stall turns the slot into a bubble.
	always_ff @(posedge clk) begin
		if (!rst_n || stall) begin
			e_rs <= '0;
			e_rt <= '0;
			e_dest <= '0;
			e_reg_write <= 1'b0;
			e_mem_write <= 1'b0;
			e_wb_sel <= wb_alu;
			e_alu_op <= alu_add;
			e_alu_src <= 1'b0;
		end else begin
			e_rs <= d_rs;
			e_rt <= d_rt;
			e_dest <= dest;
			e_reg_write <= reg_write;
			e_mem_write <= mem_write;
			e_wb_sel <= wb_sel;
			e_alu_op <= alu_op;
			e_alu_src <= alu_src;
		end
	end

	always_ff @(posedge clk) begin
		e_a <= a;
		e_b <= b;
		e_imm <= imm;
	end

endmodule

//--- verilog/hazard_unit.sv
module hazard_unit (
	input  logic              [4:0] d_rs,
	input  logic              [4:0] d_rt,
	input  logic                    d_uses_rt,
	input  logic                    d_is_branch,
	input  logic              [4:0] e_rs,
	input  logic              [4:0] e_rt,
	input  logic              [4:0] e_dest,
	input  logic                    e_reg_write,
	input  cpu_pkg::wb_sel_e        e_wb_sel,
	input  logic              [4:0] m_dest,
	input  logic                    m_reg_write,
	input  cpu_pkg::wb_sel_e        m_wb_sel,
	input  logic              [4:0] w_dest,
	input  logic                    w_reg_write,
	output logic                    stall,
	output cpu_pkg::fwd_sel_e       fwd_d1,
	output cpu_pkg::fwd_sel_e       fwd_d2,
	output cpu_pkg::fwd_sel_e       fwd_e1,
	output cpu_pkg::fwd_sel_e       fwd_e2,
	output cpu_pkg::fwd_sel_e       fwd_m
);
	import cpu_pkg::*;

	logic load_use;
	logic branch_dep;

	// the memory stage wins over writeback; a load in memory has no result yet.
	function automatic fwd_sel_e pick(input logic [4:0] src, input logic [4:0] md,
		input logic mw, input wb_sel_e ms, input logic [4:0] wd, input logic ww);
		if (src == 5'd0) begin
			return fwd_reg;
		end else if (mw && ms == wb_alu && md == src) begin
			return fwd_mem;
		end else if (ww && wd == src) begin
			return fwd_wb;
		end
		return fwd_reg;
	endfunction

	always_comb begin
		fwd_d1 = pick(d_rs, m_dest, m_reg_write, m_wb_sel, w_dest, w_reg_write);
		fwd_d2 = pick(d_rt, m_dest, m_reg_write, m_wb_sel, w_dest, w_reg_write);
		fwd_e1 = pick(e_rs, m_dest, m_reg_write, m_wb_sel, w_dest, w_reg_write);
		fwd_e2 = pick(e_rt, m_dest, m_reg_write, m_wb_sel, w_dest, w_reg_write);
	end

	// a store in memory carries its data register in m_dest.
	assign fwd_m = (!m_reg_write && w_reg_write && w_dest != 5'd0 && w_dest == m_dest)
		? fwd_wb : fwd_reg;

	assign load_use = e_reg_write && e_wb_sel == wb_load && e_dest != 5'd0
		&& (e_dest == d_rs || (d_uses_rt && e_dest == d_rt));

	assign branch_dep = d_is_branch
		&& ((e_reg_write && e_dest != 5'd0 && (e_dest == d_rs || e_dest == d_rt))
		|| (m_reg_write && m_wb_sel == wb_load && m_dest != 5'd0
		&& (m_dest == d_rs || m_dest == d_rt)));

	assign stall = load_use || branch_dep;

endmodule

//--- verilog/execute_stage.sv
module execute_stage (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic              [4:0] e_dest,
	input  logic                    e_reg_write,
	input  logic                    e_mem_write,
	input  cpu_pkg::wb_sel_e        e_wb_sel,
	input  cpu_pkg::alu_op_e        e_alu_op,
	input  logic                    e_alu_src,
	input  logic             [31:0] e_a,
	input  logic             [31:0] e_b,
	input  logic             [31:0] e_imm,
	input  cpu_pkg::fwd_sel_e       fwd_e1,
	input  cpu_pkg::fwd_sel_e       fwd_e2,
	input  logic             [31:0] w_data,
	output logic             [31:0] m_alu_result,
	output logic             [31:0] m_store_data,
	output logic              [4:0] m_dest,
	output logic                    m_reg_write,
	output logic                    m_mem_write,
	output cpu_pkg::wb_sel_e        m_wb_sel
);
	import cpu_pkg::*;

	logic [31:0] op_a, reg_b, op_b, result;

	assign op_a = (fwd_e1 == fwd_mem) ? m_alu_result : (fwd_e1 == fwd_wb) ? w_data : e_a;
	assign reg_b = (fwd_e2 == fwd_mem) ? m_alu_result : (fwd_e2 == fwd_wb) ? w_data : e_b;
	assign op_b = e_alu_src ? e_imm : reg_b;

	always_comb begin
		case (e_alu_op)
			alu_sub: result = op_a - op_b;
			alu_and: result = op_a & op_b;
			alu_or: result = op_a | op_b;
			alu_slt: result = {31'd0, $signed(op_a) < $signed(op_b)};
			alu_lui: result = {op_b[15:0], 16'd0};
			default: result = op_a + op_b; // also the address of lw and sw.
		endcase
	end

	// E/M register.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			m_dest <= '0;
			m_reg_write <= 1'b0;
			m_mem_write <= 1'b0;
			m_wb_sel <= wb_alu;
		end else begin
			m_dest <= e_dest;
			m_reg_write <= e_reg_write;
			m_mem_write <= e_mem_write;
			m_wb_sel <= e_wb_sel;
		end
	end

	always_ff @(posedge clk) begin
		m_alu_result <= result;
		m_store_data <= reg_b;
	end

endmodule

//--- verilog/memory_writeback.sv
module memory_writeback (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic             [31:0] m_alu_result,
	input  logic             [31:0] m_store_data,
	input  logic              [4:0] m_dest,
	input  logic                    m_reg_write,
	input  logic                    m_mem_write,
	input  cpu_pkg::wb_sel_e        m_wb_sel,
	input  cpu_pkg::fwd_sel_e       fwd_m,
	output logic             [31:0] w_data,
	output logic              [4:0] w_dest,
	output logic                    w_reg_write,
	output logic                    trace_valid,
	output logic              [4:0] trace_reg,
	output logic             [31:0] trace_data
);
	import cpu_pkg::*;

	logic [31:0] dmem [dmem_depth];
	logic [31:0] store_data, load_data;
	logic [31:0] w_alu, w_load;
	wb_sel_e     w_wb_sel;

	// a load just ahead of the store supplies its data from writeback.
	assign store_data = (fwd_m == fwd_wb) ? w_data : m_store_data;
	assign load_data = dmem[m_alu_result[$clog2(dmem_depth)+1:2]];

	always_ff @(posedge clk) begin
		if (m_mem_write) begin
			dmem[m_alu_result[$clog2(dmem_depth)+1:2]] <= store_data;
		end
	end

	// M/W register.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			w_dest <= '0;
			w_reg_write <= 1'b0;
			w_wb_sel <= wb_alu;
		end else begin
			w_dest <= m_dest;
			w_reg_write <= m_reg_write;
			w_wb_sel <= m_wb_sel;
		end
	end

	always_ff @(posedge clk) begin
		w_alu <= m_alu_result;
		w_load <= load_data;
	end

	assign w_data = (w_wb_sel == wb_load) ? w_load : w_alu;

	assign trace_valid = w_reg_write && w_dest != 5'd0; // register 0 writes stay silent.
	assign trace_reg = w_dest;
	assign trace_data = w_data;

endmodule

//--- verilog/cpu.sv
module cpu (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               imem_we,
	input  logic [cpu_pkg::imem_addr_bits-1:0] imem_addr,
	input  logic [31:0]                        imem_data,
	output logic                               trace_valid,
	output logic [4:0]                         trace_reg,
	output logic [31:0]                        trace_data
);
	import cpu_pkg::*;

	// -------------------------------------------------------------------
	// stage to stage wiring
	// -------------------------------------------------------------------
	logic [31:0] d_instr, d_pc_plus4, target;
	logic        redirect, stall;
	logic [4:0]  d_rs, d_rt, e_rs, e_rt, e_dest, m_dest, w_dest;
	logic        d_uses_rt, d_is_branch;
	logic        e_reg_write, e_mem_write, e_alu_src;
	logic [31:0] e_a, e_b, e_imm;
	wb_sel_e     e_wb_sel, m_wb_sel;
	alu_op_e     e_alu_op;
	logic [31:0] m_alu_result, m_store_data, w_data;
	logic        m_reg_write, m_mem_write, w_reg_write;
	fwd_sel_e    fwd_d1, fwd_d2, fwd_e1, fwd_e2, fwd_m;

	fetch_stage u_fetch (
		.clk(clk), .rst_n(rst_n),
		.imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
		.stall(stall), .redirect(redirect), .target(target),
		.d_instr(d_instr), .d_pc_plus4(d_pc_plus4)
	);

	decode_stage u_decode (
		.clk(clk), .rst_n(rst_n), .stall(stall),
		.d_instr(d_instr), .d_pc_plus4(d_pc_plus4),
		.fwd_d1(fwd_d1), .fwd_d2(fwd_d2), .m_alu_result(m_alu_result),
		.w_data(w_data), .w_dest(w_dest), .w_reg_write(w_reg_write),
		.redirect(redirect), .target(target),
		.d_rs(d_rs), .d_rt(d_rt), .d_uses_rt(d_uses_rt), .d_is_branch(d_is_branch),
		.e_rs(e_rs), .e_rt(e_rt), .e_dest(e_dest),
		.e_reg_write(e_reg_write), .e_mem_write(e_mem_write), .e_wb_sel(e_wb_sel),
		.e_alu_op(e_alu_op), .e_alu_src(e_alu_src),
		.e_a(e_a), .e_b(e_b), .e_imm(e_imm)
	);

	hazard_unit u_hazard (
		.d_rs(d_rs), .d_rt(d_rt), .d_uses_rt(d_uses_rt), .d_is_branch(d_is_branch),
		.e_rs(e_rs), .e_rt(e_rt), .e_dest(e_dest),
		.e_reg_write(e_reg_write), .e_wb_sel(e_wb_sel),
		.m_dest(m_dest), .m_reg_write(m_reg_write), .m_wb_sel(m_wb_sel),
		.w_dest(w_dest), .w_reg_write(w_reg_write),
		.stall(stall), .fwd_d1(fwd_d1), .fwd_d2(fwd_d2),
		.fwd_e1(fwd_e1), .fwd_e2(fwd_e2), .fwd_m(fwd_m)
	);

	execute_stage u_execute (
		.clk(clk), .rst_n(rst_n),
		.e_dest(e_dest), .e_reg_write(e_reg_write), .e_mem_write(e_mem_write),
		.e_wb_sel(e_wb_sel), .e_alu_op(e_alu_op), .e_alu_src(e_alu_src),
		.e_a(e_a), .e_b(e_b), .e_imm(e_imm),
		.fwd_e1(fwd_e1), .fwd_e2(fwd_e2), .w_data(w_data),
		.m_alu_result(m_alu_result), .m_store_data(m_store_data), .m_dest(m_dest),
		.m_reg_write(m_reg_write), .m_mem_write(m_mem_write), .m_wb_sel(m_wb_sel)
	);

	memory_writeback u_mem_wb (
		.clk(clk), .rst_n(rst_n),
		.m_alu_result(m_alu_result), .m_store_data(m_store_data), .m_dest(m_dest),
		.m_reg_write(m_reg_write), .m_mem_write(m_mem_write), .m_wb_sel(m_wb_sel),
		.fwd_m(fwd_m),
		.w_data(w_data), .w_dest(w_dest), .w_reg_write(w_reg_write),
		.trace_valid(trace_valid), .trace_reg(trace_reg), .trace_data(trace_data)
	);

endmodule

//--- tests/tb_clock.sv
module tb_clock (
	output logic clk
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period.
	end

endmodule

//--- tests/cpu_checker.sv
module cpu_checker (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        trace_valid,
	input  logic [4:0]  trace_reg,
	input  logic [31:0] trace_data,
	input  logic        exp_active,
	input  logic        exp_last,
	input  int          exp_group,
	input  logic [4:0]  exp_reg,
	input  logic [31:0] exp_data,
	output int          beats,
	output int          groups_passed,
	output int          errors
);
	timeunit 1ns;
	timeprecision 100ps;

	int group_beats;
	int group_errors;

	// each trace beat is matched against the entry the testbench holds up.
	always @(posedge clk) begin
		if (!rst_n) begin
			beats = 0;
			groups_passed = 0;
			errors = 0;
			group_beats = 0;
			group_errors = 0;
		end else if (trace_valid) begin
			if (!exp_active) begin
				$display("unexpected write of %08h to r%0d at %0d ns, no writeback was expected",
					trace_data, trace_reg, $time);
				errors++;
			end else begin
				if (trace_reg !== exp_reg) begin
					$display("FAILED at %0d ns: trace_reg = %0d, expected %0d",
						$time, trace_reg, exp_reg);
					group_errors++;
					errors++;
				end
				if (trace_data !== exp_data) begin
					$display("FAILED at %0d ns: trace_data = %08h, expected %08h",
						$time, trace_data, exp_data);
					group_errors++;
					errors++;
				end
				group_beats++;
				beats++;
				if (exp_last) begin
					if (group_errors == 0) begin
						$display("group %0d passed, %0d writebacks", exp_group, group_beats);
						groups_passed++;
					end else begin
						$display("group %0d failed, %0d mismatches in %0d writebacks",
							exp_group, group_errors, group_beats);
					end
					group_beats = 0;
					group_errors = 0;
				end
			end
		end
	end

endmodule

//--- tests/cpu_props.sv
module cpu_props (
	input logic       clk,
	input logic       rst_n,
	input logic       trace_valid,
	input logic [4:0] trace_reg,
	input logic       stall
);
	timeunit 1ns;
	timeprecision 100ps;

	quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !trace_valid)
		else $error("trace_valid is high while the core is in reset.");

	// writes to register 0 never show up on the trace.
	no_trace_of_r0: assert property (@(posedge clk) disable iff (!rst_n)
		trace_valid |-> trace_reg != 5'd0)
		else $error("trace_valid is high with trace_reg equal to 0.");

	single_cycle_stall: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> !stall)
		else $error("stall was high for two cycles in a row.");

endmodule

//--- tests/tb_cpu.sv
module tb_cpu;
	timeunit 1ns;
	timeprecision 100ps;

	import cpu_pkg::*;

	localparam int beat_timeout = 20; // cycles allowed between two writebacks.
	localparam int num_groups = 5;

	logic                      clk;
	logic                      rst_n;
	logic                      imem_we;
	logic [imem_addr_bits-1:0] imem_addr;
	logic [31:0]               imem_data;
	logic                      trace_valid;
	logic [4:0]                trace_reg;
	logic [31:0]               trace_data;

	logic        exp_active;
	logic        exp_last;
	int          exp_group_now;
	logic [4:0]  exp_reg_now;
	logic [31:0] exp_data_now;
	int          beats;
	int          groups_passed;
	int          errors;

	logic [31:0] prog [$];
	int          exp_group [$];
	logic [4:0]  exp_reg [$];
	logic [31:0] exp_data [$];
	string       group_name [num_groups];

	tb_clock i_clock (.clk(clk));

	cpu i_dut (
		.clk(clk), .rst_n(rst_n),
		.imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
		.trace_valid(trace_valid), .trace_reg(trace_reg), .trace_data(trace_data)
	);

	cpu_checker i_check (
		.clk(clk), .rst_n(rst_n),
		.trace_valid(trace_valid), .trace_reg(trace_reg), .trace_data(trace_data),
		.exp_active(exp_active), .exp_last(exp_last), .exp_group(exp_group_now),
		.exp_reg(exp_reg_now), .exp_data(exp_data_now),
		.beats(beats), .groups_passed(groups_passed), .errors(errors)
	);

	bind cpu cpu_props i_props (
		.clk(clk), .rst_n(rst_n), .trace_valid(trace_valid),
		.trace_reg(trace_reg), .stall(stall)
	);

	// -------------------------------------------------------------------
	// instruction encoding
	// -------------------------------------------------------------------
	function automatic logic [31:0] rtype(input funct_e fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
		return {6'h00, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] itype(input opcode_e op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jtype(input logic [31:0] addr);
		return {op_j, addr[27:2]};
	endfunction

	task automatic emit(input logic [31:0] word);
		prog.push_back(word);
	endtask

	task automatic expect_write(input int g, input logic [4:0] r, input logic [31:0] d);
		exp_group.push_back(g);
		exp_reg.push_back(r);
		exp_data.push_back(d);
	endtask

	// -------------------------------------------------------------------
	// program and expected writebacks
	// -------------------------------------------------------------------
	task automatic build_tables();
		group_name[0] = "immediates and alu";
		group_name[1] = "forwarding";
		group_name[2] = "load and store";
		group_name[3] = "branches and delay slot";
		group_name[4] = "jump and register 0";

		emit(itype(op_ori, 5'd1, 5'd0, 16'h1234)); // 0x00
		emit(itype(op_lui, 5'd2, 5'd0, 16'h8000));
		emit(itype(op_ori, 5'd3, 5'd0, 16'h00f0));
		emit(itype(op_ori, 5'd4, 5'd0, 16'h0ff0));
		emit(32'h0000_0000);
		emit(32'h0000_0000);
		emit(rtype(fn_addu, 5'd5, 5'd1, 5'd3)); // 0x18
		emit(rtype(fn_subu, 5'd6, 5'd3, 5'd1));
		emit(rtype(fn_and, 5'd7, 5'd1, 5'd4));
		emit(rtype(fn_or, 5'd8, 5'd2, 5'd3));
		emit(rtype(fn_slt, 5'd9, 5'd2, 5'd1));
		emit(rtype(fn_slt, 5'd10, 5'd1, 5'd2));

		// each result feeds the next one or two instructions.
		emit(itype(op_ori, 5'd11, 5'd0, 16'h0010)); // 0x30
		emit(rtype(fn_addu, 5'd12, 5'd11, 5'd11));
		emit(rtype(fn_subu, 5'd13, 5'd12, 5'd11));
		emit(rtype(fn_or, 5'd14, 5'd13, 5'd12));
		emit(rtype(fn_slt, 5'd15, 5'd11, 5'd14));
		emit(rtype(fn_and, 5'd16, 5'd14, 5'd13));

		emit(itype(op_sw, 5'd14, 5'd11, 16'd8)); // 0x48
		emit(itype(op_lw, 5'd17, 5'd11, 16'd8));
		emit(rtype(fn_addu, 5'd18, 5'd17, 5'd11)); // load-use stall.
		emit(itype(op_sw, 5'd18, 5'd0, 16'd0));
		emit(itype(op_lw, 5'd19, 5'd0, 16'd0));
		emit(itype(op_sw, 5'd19, 5'd0, 16'd4)); // store data comes from writeback.
		emit(itype(op_lw, 5'd20, 5'd0, 16'd4));

		emit(itype(op_ori, 5'd21, 5'd0, 16'h0007)); // 0x64
		emit(itype(op_ori, 5'd22, 5'd0, 16'h0007));
		emit(itype(op_beq, 5'd22, 5'd21, 16'd2)); // taken, to 0x78.
		emit(itype(op_ori, 5'd23, 5'd0, 16'h0011));
		emit(itype(op_ori, 5'd30, 5'd0, 16'h0bad));
		emit(itype(op_beq, 5'd21, 5'd23, 16'd3)); // 0x78, not taken.
		emit(itype(op_ori, 5'd24, 5'd0, 16'h0022));
		emit(itype(op_ori, 5'd25, 5'd0, 16'h0033));

		emit(jtype(32'h0000_0090)); // 0x84
		emit(itype(op_ori, 5'd26, 5'd0, 16'h0044));
		emit(itype(op_ori, 5'd31, 5'd0, 16'h0bad));
		emit(rtype(fn_addu, 5'd0, 5'd21, 5'd22)); // 0x90
		emit(rtype(fn_addu, 5'd28, 5'd0, 5'd21));
		emit(rtype(fn_addu, 5'd29, 5'd0, 5'd26));
		emit(jtype(32'h0000_009c)); // the core parks here.
		emit(32'h0000_0000);

		expect_write(1, 5'd1, 32'h0000_1234);
		expect_write(1, 5'd2, 32'h8000_0000);
		expect_write(1, 5'd3, 32'h0000_00f0);
		expect_write(1, 5'd4, 32'h0000_0ff0);
		expect_write(1, 5'd5, 32'h0000_1324);
		expect_write(1, 5'd6, 32'hffff_eebc);
		expect_write(1, 5'd7, 32'h0000_0230);
		expect_write(1, 5'd8, 32'h8000_00f0);
		expect_write(1, 5'd9, 32'h0000_0001);
		expect_write(1, 5'd10, 32'h0000_0000);
		expect_write(2, 5'd11, 32'h0000_0010);
		expect_write(2, 5'd12, 32'h0000_0020);
		expect_write(2, 5'd13, 32'h0000_0010);
		expect_write(2, 5'd14, 32'h0000_0030);
		expect_write(2, 5'd15, 32'h0000_0001);
		expect_write(2, 5'd16, 32'h0000_0010);
		expect_write(3, 5'd17, 32'h0000_0030);
		expect_write(3, 5'd18, 32'h0000_0040);
		expect_write(3, 5'd19, 32'h0000_0040);
		expect_write(3, 5'd20, 32'h0000_0040);
		expect_write(4, 5'd21, 32'h0000_0007);
		expect_write(4, 5'd22, 32'h0000_0007);
		expect_write(4, 5'd23, 32'h0000_0011);
		expect_write(4, 5'd24, 32'h0000_0022);
		expect_write(4, 5'd25, 32'h0000_0033);
		expect_write(5, 5'd26, 32'h0000_0044);
		expect_write(5, 5'd28, 32'h0000_0007);
		expect_write(5, 5'd29, 32'h0000_0044);
	endtask

	task automatic load_program();
		for (int i = 0; i < prog.size(); i++) begin
			@(posedge clk);
			#1;
			imem_we = 1'b1;
			imem_addr = imem_addr_bits'(i);
			imem_data = prog[i];
		end
		@(posedge clk);
		#1;
		imem_we = 1'b0;
	endtask

	task automatic wait_for_beat(output logic got);
		int prev;
		int cycles;
		prev = beats;
		cycles = 0;
		got = 1'b0;
		while (!got && cycles < beat_timeout) begin
			@(posedge clk);
			#1;
			cycles++;
			got = (beats != prev);
		end
	endtask

	initial begin
		int k;
		logic got;
		logic timed_out;
		rst_n = 1'b0;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_data = '0;
		exp_active = 1'b0;
		exp_last = 1'b0;
		exp_group_now = 0;
		exp_reg_now = '0;
		exp_data_now = '0;
		timed_out = 1'b0;
		build_tables();
		load_program(); // the load port only works while rst_n is low.
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;

		k = 0;
		while (k < exp_reg.size() && !timed_out) begin
			exp_active = 1'b1;
			exp_group_now = exp_group[k];
			exp_reg_now = exp_reg[k];
			exp_data_now = exp_data[k];
			exp_last = (k == exp_reg.size() - 1) || (exp_group[k + 1] != exp_group[k]);
			wait_for_beat(got);
			if (!got) begin
				$display("group %0d (%s) stalled, the write to r%0d did not arrive in %0d cycles",
					exp_group[k], group_name[exp_group[k] - 1], exp_reg[k], beat_timeout);
				timed_out = 1'b1;
			end
			k++;
		end
		exp_active = 1'b0;
		repeat (12) @(posedge clk); // the parked core must stay silent.

		$display("groups passed: %0d, groups failed: %0d",
			groups_passed, num_groups - groups_passed);
		if (!timed_out && errors == 0 && groups_passed == num_groups) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- all.f
verilog/cpu_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/hazard_unit.sv
verilog/execute_stage.sv
verilog/memory_writeback.sv
verilog/cpu.sv
tests/tb_clock.sv
tests/cpu_checker.sv
tests/cpu_props.sv
tests/tb_cpu.sv

//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module tb_cpu -f all.f

sim:
	verilator --binary --assert -j 0 --top-module tb_cpu -f all.f
	./obj_dir/Vtb_cpu | tee sim.log
	grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log
